/* Makefile */
SIM       := verilator
FLAGS     := --binary --timing -Wno-fatal
TOP       := tb_byte_stream_buffer
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "result: fail"; exit 1; \
	elif ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "result: no verdict in $(LOG)"; exit 1; \
	else \
		echo "result: pass"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+tb
verilog/stream_fmt_pkg.sv
verilog/ram_cfg_pkg.sv
verilog/byte_packer.sv
verilog/sdp_bram.sv
verilog/word_drainer.sv
verilog/byte_stream_buffer.sv
tb/tb_byte_stream_buffer.sv

/* tb/stream_model.svh */
`ifndef STREAM_MODEL_SVH
`define STREAM_MODEL_SVH

// reference model of the buffer that lives inside the testbench module
// expects DEPTH and the stream_fmt_pkg types in the including scope

word_u model_q[$];          // committed words not yet seen at the output
word_u open_word;           // word being packed with unused lanes left at zero
int    open_lanes;
logic  model_overflow;
int    dropped_words;

int    errors;
int    word_checks;
int    flag_checks;

task automatic model_reset();
    model_q.delete();
    open_word.word = '0;
    open_lanes     = 0;
    model_overflow = 1'b0;
endtask

// buffer keeps DEPTH-1 words and a full one gives up its oldest
task automatic model_commit();
    if (model_q.size() == DEPTH - 1) begin
        void'(model_q.pop_front());
        model_overflow = 1'b1;   // sticky until the next reset
        dropped_words++;
    end
    model_q.push_back(open_word);
    open_word.word = '0;
    open_lanes     = 0;
endtask

// one input cycle with the byte placed before the flush
task automatic model_step(input logic valid, input byte_t data, input logic flush_in);
    if (valid) begin
        open_word.lane[open_lanes] = data;   // earliest byte in lane 0
        open_lanes++;
        if (open_lanes == BYTE_LANES) begin
            model_commit();
        end
    end
    if (flush_in && open_lanes != 0) begin
        model_commit();   // upper lanes already zero
    end
endtask

task automatic check_word(input string name, input word_u exp, input word_u act);
    word_checks++;
    if (act.word !== exp.word) begin
        errors++;
        $display("ERR %s expected %08h actual %08h", name, exp.word, act.word);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    flag_checks++;
    if (act !== exp) begin
        errors++;
        $display("ERR %s expected %0b actual %0b", name, exp, act);
    end
endtask

`endif

/* tb/tb_byte_stream_buffer.sv */
`timescale 1ns/1ns

module tb_byte_stream_buffer
    import stream_fmt_pkg::*;
();
    localparam int ADDR_WIDTH   = 4;
    localparam int DEPTH        = 2**ADDR_WIDTH;
    localparam int PERIOD       = 8;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 1;

    // cycle budget of the whole run
    localparam int STREAM_CYCLES   = 300;
    localparam int FLUSH_CYCLES    = 200;
    localparam int MIXED_CYCLES    = 300;
    localparam int IDLE_CYCLES     = 64;
    localparam int WORD_MAX_CYCLES = 20;   // four bytes with gaps of up to three cycles plus a flush
    localparam int DIRECTED_WORDS  = 48;
    localparam int DRAIN_LIMIT     = 64;
    localparam int DRAIN_WAITS     = 10;
    localparam int STIM_CYCLES     = 2 * RESET_CYCLES + IDLE_CYCLES + 2 * STREAM_CYCLES
                                   + FLUSH_CYCLES + MIXED_CYCLES
                                   + DIRECTED_WORDS * WORD_MAX_CYCLES;
    localparam int DRAIN_MARGIN    = DRAIN_WAITS * (DRAIN_LIMIT + 10);
    localparam int WATCHDOG_NS     = (STIM_CYCLES + DRAIN_MARGIN) * PERIOD;

    logic  clk;
    logic  reset_reg;
    logic  in_valid;
    byte_t in_byte;
    logic  flush;
    logic  hold;
    logic  out_valid;
    word_u out_word;
    logic  overflow;

    string test_name;
    logic  hold_d1;      // hold as seen one and two cycles back
    logic  hold_d2;
    word_u exp_word;

    `include "stream_model.svh"

    byte_stream_buffer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) uut (
        .clk       (clk),
        .reset_reg (reset_reg),
        .in_valid  (in_valid),
        .in_byte   (in_byte),
        .flush     (flush),
        .hold      (hold),
        .out_valid (out_valid),
        .out_word  (out_word),
        .overflow  (overflow)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    // inputs change just after the rising edge and the model sees the same cycle
    task automatic drive(input logic v, input byte_t b, input logic f, input logic h);
        @(posedge clk);
        #(DRIVE_DELAY);
        in_valid = v;
        in_byte  = b;
        flush    = f;
        hold     = h;
        model_step(v, b, f);
    endtask

    task automatic idle(input int cycles, input logic h);
        repeat (cycles) begin
            drive(1'b0, 8'h00, 1'b0, h);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #(DRIVE_DELAY);
        reset_reg = 1'b1;
        in_valid  = 1'b0;
        flush     = 1'b0;
        hold      = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset_reg = 1'b0;
    endtask

    // len bytes then a flush in the last byte's cycle or the next one
    task automatic short_word(input int len, input logic same_cycle, input logic h);
        for (int i = 0; i < len; i++) begin
            drive(1'b1, byte_t'($urandom), same_cycle && (i == len - 1), h);
        end
        if (!same_cycle) begin
            drive(1'b0, 8'h00, 1'b1, h);
        end
    endtask

    // exactly one committed word that is usually full
    task automatic send_word(input logic h);
        int   len;
        int   gap;
        logic same_cycle;
        len        = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : BYTE_LANES;
        same_cycle = ($urandom_range(0, 1) == 1);
        for (int i = 0; i < len; i++) begin
            gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
            idle(gap, h);
            drive(1'b1, byte_t'($urandom), (i == len - 1) && len < BYTE_LANES && same_cycle, h);
        end
        if (len < BYTE_LANES && !same_cycle) begin
            drive(1'b0, 8'h00, 1'b1, h);
        end
    endtask

    // random bytes and flushes with short hold bursts and a quiet gap after each burst
    task automatic random_stream(input int cycles, input int flush_pct, input logic hold_phases);
        int   hold_left;
        int   rest;
        logic v;
        logic f;
        logic h;
        hold_left = 0;
        rest      = 0;
        for (int c = 0; c < cycles; c++) begin
            v = $urandom_range(0, 99) < 70;
            f = $urandom_range(0, 99) < flush_pct;
            h = 1'b0;
            if (hold_phases && hold_left == 0 && rest == 0 && $urandom_range(0, 15) == 0) begin
                hold_left = $urandom_range(1, 6);
                rest      = 8;
            end
            if (hold_left > 0) begin
                h = 1'b1;
                hold_left--;
            end else if (rest > 0) begin
                rest--;
            end
            drive(v, byte_t'($urandom), f, h);
        end
        drive(1'b0, 8'h00, 1'b1, 1'b0);   // close a partial word
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        idle(1, 1'b0);
        while (model_q.size() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (model_q.size() != 0) begin
            errors++;
            $display("%s: %0d words never came out of the buffer", test_name, model_q.size());
            model_q.delete();
        end
        idle(8, 1'b0);   // any extra word shows up here
    endtask

    task automatic print_counts();
        $display("summary: %0d errors, %0d words checked, %0d flag checks",
                 errors, word_checks, flag_checks);
    endtask

    // output monitor sampled mid-cycle
    always @(negedge clk) begin
        if (reset_reg) begin
            hold_d1 = 1'b0;
            hold_d2 = 1'b0;
        end else begin
            if (out_valid) begin
                if (hold_d2) begin
                    errors++;
                    $display("%s: a word came out while hold was high", test_name);
                end
                if (model_q.size() == 0) begin
                    errors++;
                    $display("%s: word %08h came out with no word expected",
                             test_name, out_word.word);
                end else begin
                    exp_word = model_q.pop_front();
                    check_word(test_name, exp_word, out_word);
                end
            end
            hold_d2 = hold_d1;
            hold_d1 = hold;
        end
    end

    initial begin
        int extra;
        void'($urandom(32'h7ba4));
        reset_reg = 1'b1;
        in_valid  = 1'b0;
        in_byte   = 8'h00;
        flush     = 1'b0;
        hold      = 1'b0;
        hold_d1   = 1'b0;
        hold_d2   = 1'b0;
        test_name = "reset";
        apply_reset();

        test_name = "idle_after_reset";
        idle(24, 1'b0);
        @(negedge clk);
        check_flag({test_name, " out_valid"}, 1'b0, out_valid);
        check_flag({test_name, " overflow"}, 1'b0, overflow);

        test_name = "stream";
        random_stream(STREAM_CYCLES, 0, 1'b0);
        wait_drained(DRAIN_LIMIT);

        test_name = "flush";
        for (int len = 1; len < BYTE_LANES; len++) begin
            short_word(len, 1'b0, 1'b0);
            short_word(len, 1'b1, 1'b0);
        end
        drive(1'b0, 8'h00, 1'b1, 1'b0);   // flush with nothing open
        drive(1'b0, 8'h00, 1'b1, 1'b0);
        random_stream(FLUSH_CYCLES, 12, 1'b0);
        wait_drained(DRAIN_LIMIT);

        test_name = "hold_keep";
        idle(4, 1'b1);
        repeat (DEPTH - 2) send_word(1'b1);
        idle(6, 1'b1);
        wait_drained(DRAIN_LIMIT);
        check_flag({test_name, " overflow"}, 1'b0, overflow);

        test_name     = "overflow";
        extra         = $urandom_range(3, 7);
        dropped_words = 0;
        idle(4, 1'b1);
        repeat (DEPTH - 1 + extra) send_word(1'b1);
        idle(6, 1'b1);
        @(negedge clk);
        check_flag({test_name, " set"}, model_overflow, overflow);
        $display("overflow phase: %0d words sent past a full buffer, %0d dropped",
                 extra, dropped_words);
        wait_drained(DRAIN_LIMIT);
        test_name = "after_overflow";
        random_stream(STREAM_CYCLES / 3, 10, 1'b0);
        wait_drained(DRAIN_LIMIT);
        check_flag({test_name, " sticky"}, 1'b1, overflow);

        test_name = "second_reset";
        apply_reset();
        @(negedge clk);
        check_flag({test_name, " overflow"}, model_overflow, overflow);
        test_name = "mixed";
        random_stream(MIXED_CYCLES, 5, 1'b1);
        wait_drained(DRAIN_LIMIT);
        check_flag({test_name, " overflow"}, 1'b0, overflow);

        print_counts();
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // run length limit
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        print_counts();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verilog/byte_packer.sv */
`timescale 1ns/1ns

module byte_packer
    import stream_fmt_pkg::*;
#(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset_reg,
    input  logic                  in_valid,
    input  byte_t                 in_byte,
    input  logic                  flush,
    output logic [ADDR_WIDTH-1:0] waddr,
    output lane_mask_t            write_en,
    output word_u                 wdata,
    output logic                  commit
);
    logic [LANE_BITS-1:0]  lane_idx;     // next free lane of the open word
    logic [ADDR_WIDTH-1:0] wptr;         // ram slot of the open word

    logic [LANE_BITS:0]    filled;       // lanes used once this cycle's byte is in
    logic                  full;
    logic                  pad;
    logic                  word_done;
    logic                  word_done_q;  // final lane goes into the ram next edge
    lane_mask_t            next_mask;
    word_u                 next_data;

    assign filled = {1'b0, lane_idx} + (LANE_BITS + 1)'(in_valid);
    assign full   = filled == (LANE_BITS + 1)'(BYTE_LANES);

    // flush only matters on a partly filled word
    assign pad       = flush && filled != '0 && !full;
    assign word_done = full || pad;

    // build this cycle's lane writes
    always_comb begin
        next_mask      = '0;
        next_data.word = '0;   // unfilled lanes pad with zero
        if (in_valid) begin
            next_mask[lane_idx]      = 1'b1;
            next_data.lane[lane_idx] = in_byte;
        end
        if (pad) begin
            // byte goes in first, the rest of the word is zeroed in one write
            for (int i = 0; i < BYTE_LANES; i++) begin
                if (i >= int'(filled)) begin
                    next_mask[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_reg) begin
            lane_idx    <= '0;
            wptr        <= '0;
            write_en    <= '0;
            word_done_q <= 1'b0;
            commit      <= 1'b0;
        end else begin
            write_en    <= next_mask;
            word_done_q <= word_done;
            commit      <= word_done_q;   // word is fully in ram by now
            if (word_done) begin
                lane_idx <= '0;
                wptr     <= wptr + 1'b1;
            end else if (in_valid) begin
                lane_idx <= lane_idx + 1'b1;
            end
        end
    end

    // write port payload
    always_ff @(posedge clk) begin
        waddr <= wptr;
        wdata <= next_data;
    end

endmodule

/* verilog/byte_stream_buffer.sv */
`timescale 1ns/1ns

module byte_stream_buffer
    import stream_fmt_pkg::*;
#(
    parameter int ADDR_WIDTH = 4
) (
    input  logic  clk,
    input  logic  reset_reg,
    input  logic  in_valid,
    input  byte_t in_byte,
    input  logic  flush,
    input  logic  hold,
    output logic  out_valid,
    output word_u out_word,
    output logic  overflow
);
    // write side
    logic [ADDR_WIDTH-1:0] waddr;
    lane_mask_t            write_en;
    word_u                 wdata;
    logic                  commit;

    // read side
    logic [ADDR_WIDTH-1:0] raddr;
    logic                  rd_en;
    word_u                 rdata;

    byte_packer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_packer (
        .clk       (clk),
        .reset_reg (reset_reg),
        .in_valid  (in_valid),
        .in_byte   (in_byte),
        .flush     (flush),
        .waddr     (waddr),
        .write_en  (write_en),
        .wdata     (wdata),
        .commit    (commit)
    );

    sdp_bram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk       (clk),
        .reset_reg (reset_reg),
        .rd_en     (rd_en),
        .raddr     (raddr),
        .waddr     (waddr),
        .write_en  (write_en),
        .wdata     (wdata),
        .rdata     (rdata)
    );

    word_drainer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_drainer (
        .clk       (clk),
        .reset_reg (reset_reg),
        .commit    (commit),
        .hold      (hold),
        .rdata     (rdata),
        .raddr     (raddr),
        .rd_en     (rd_en),
        .out_valid (out_valid),
        .out_word  (out_word),
        .overflow  (overflow)
    );

endmodule

/* verilog/ram_cfg_pkg.sv */
package ram_cfg_pkg;

    // read port value while the delayed reset is high
    localparam logic [31:0] RAM_RESET_WORD = 32'h0000_0000;

    // read port value after a same-address read/write collision
    localparam logic [31:0] RAM_POISON_WORD = 32'hdead_beef;

endpackage

/* verilog/sdp_bram.sv */
`timescale 1ns/1ns

module sdp_bram
    import stream_fmt_pkg::*;
    import ram_cfg_pkg::*;
#(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset_reg,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] raddr,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  lane_mask_t            write_en,
    input  word_u                 wdata,
    output word_u                 rdata
);
    localparam int DEPTH = 2**ADDR_WIDTH;

    word_u                 mem [DEPTH];
    logic [ADDR_WIDTH-1:0] addr_reg;     // captured read address
    logic                  reset_q;      // reset seen one cycle late by the read port
    logic                  hazard;
    logic                  hazard_q;

    // read of the slot being written in the same cycle
    assign hazard = raddr == waddr && |write_en;

    // byte-lane writes whenever a lane enable is set
    always_ff @(posedge clk) begin
        for (int i = 0; i < BYTE_LANES; i++) begin
            if (write_en[i]) begin
                mem[waddr].lane[i] <= wdata.lane[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            addr_reg <= raddr;
        end
    end

    always_ff @(posedge clk) begin
        reset_q <= reset_reg;
        if (reset_reg) begin
            hazard_q <= 1'b0;
        end else if (rd_en) begin
            hazard_q <= hazard;
        end
    end

    // write-first so a fresh write shows up on the next read of that slot
    always_comb begin
        if (reset_q) begin
            rdata.word = RAM_RESET_WORD;
        end else if (hazard_q) begin
            rdata.word = RAM_POISON_WORD;   // data of a collided read is not trusted
        end else begin
            rdata = mem[addr_reg];
        end
    end

endmodule

/* verilog/stream_fmt_pkg.sv */
package stream_fmt_pkg;

    // four byte lanes per word
    localparam int BYTE_LANES = 4;
    localparam int LANE_BITS  = $clog2(BYTE_LANES);
    localparam int WORD_BITS  = BYTE_LANES * 8;

    typedef logic [7:0] byte_t;

    // one write enable per byte lane
    typedef logic [BYTE_LANES-1:0] lane_mask_t;

    // same 32 bits seen whole or split into lanes
    // lane 0 is the low byte and carries the earliest byte of the stream
    typedef union packed {
        logic [WORD_BITS-1:0]    word;
        byte_t [BYTE_LANES-1:0]  lane;
    } word_u;

endpackage

/* verilog/word_drainer.sv */
`timescale 1ns/1ns

module word_drainer
    import stream_fmt_pkg::*;
#(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset_reg,
    input  logic                  commit,
    input  logic                  hold,
    input  word_u                 rdata,
    output logic [ADDR_WIDTH-1:0] raddr,
    output logic                  rd_en,
    output logic                  out_valid,
    output word_u                 out_word,
    output logic                  overflow
);
    localparam int DEPTH = 2**ADDR_WIDTH;

    // one slot stays free so the writer never lands on the oldest word
    localparam logic [ADDR_WIDTH-1:0] FULL_COUNT = ADDR_WIDTH'(DEPTH - 1);

    logic [ADDR_WIDTH-1:0] rptr;        // oldest unread word
    logic [ADDR_WIDTH-1:0] count;       // committed words not yet read
    logic [ADDR_WIDTH-1:0] count_next;
    logic                  issue;
    logic                  drop;

    // at most one read per cycle
    assign issue = !hold && count != '0;

    // full and nothing leaving, the oldest word gives way
    assign drop = commit && !issue && count == FULL_COUNT;

    always_comb begin
        count_next = count;
        if (commit && !issue && !drop) begin
            count_next = count + 1'b1;
        end else if (issue && !commit) begin
            count_next = count - 1'b1;
        end
        // commit with a read, or a drop, leaves count alone
    end

    always_ff @(posedge clk) begin
        if (reset_reg) begin
            rptr      <= '0;
            count     <= '0;
            rd_en     <= 1'b0;
            out_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            count     <= count_next;
            rd_en     <= issue;
            out_valid <= rd_en;   // ram answers one cycle after the request
            if (issue || drop) begin
                rptr <= rptr + 1'b1;
            end
            if (drop) begin
                overflow <= 1'b1;   // sticky until reset
            end
        end
    end

    // read address to the ram
    always_ff @(posedge clk) begin
        if (issue) begin
            raddr <= rptr;
        end
    end

    assign out_word = rdata;

endmodule
